// ==== hw/auth_blk.sv ====
`timescale 1ns/100ps

module auth_blk (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx_rdy,     // Byte waiting in the receiver
    input  auth_pkg::byte_t rx_data,
    input  logic            rider_off,
    output logic            clr_rdy,
    output logic            pwr_up      // To the balance controller
);

    import auth_pkg::*;

    auth_state_t state;
    auth_state_t nxt_state;
    logic        go_rcvd;
    logic        stop_rcvd;

    // Command decode, only valid while a byte is pending
    assign go_rcvd   = rx_rdy && (rx_data == AUTH_GO);
    assign stop_rcvd = rx_rdy && (rx_data == AUTH_STOP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= POWERED_DOWN;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        clr_rdy   = rx_rdy;  // Every byte is consumed the cycle it shows up

        case (state)
            POWERED_DOWN: begin
                if (go_rcvd) begin
                    nxt_state = POWERED_UP;
                end
            end

            POWERED_UP: begin
                if (stop_rcvd) begin
                    // Never cut power under a rider
                    if (rider_off) begin
                        nxt_state = POWERED_DOWN;
                    end else begin
                        nxt_state = STOP_PENDING;
                    end
                end
            end

            STOP_PENDING: begin
                if (go_rcvd) begin
                    nxt_state = POWERED_UP;    // Stop request withdrawn
                end else if (rider_off) begin
                    nxt_state = POWERED_DOWN;  // Rider has stepped off
                end
            end

            default: begin
                nxt_state = POWERED_DOWN;
            end
        endcase
    end

    // Power stays on while a stop is pending
    assign pwr_up = (state == POWERED_UP) || (state == STOP_PENDING);

endmodule

// ==== hw/auth_pkg.sv ====
package auth_pkg;

    // Widths
    localparam int BYTE_W = 8;
    localparam int LD_W   = 12;
    localparam int WT_W   = LD_W + 1;     // One extra bit so the cell sum cannot overflow

    typedef logic [BYTE_W-1:0] byte_t;    // One byte from the BLE link
    typedef logic [LD_W-1:0]   ld_val_t;  // Single load-cell reading
    typedef logic [WT_W-1:0]   weight_t;  // Left plus right

    // Both load cells, left in the upper half
    typedef struct packed {
        ld_val_t lft;
        ld_val_t rght;
    } ld_cell_t;

    // Command bytes sent by the phone app
    localparam byte_t AUTH_GO   = 8'h47;  // 'G'
    localparam byte_t AUTH_STOP = 8'h53;  // 'S'

    // Authorization FSM states
    typedef enum logic [1:0] {
        POWERED_DOWN = 2'b00,
        POWERED_UP   = 2'b01,
        STOP_PENDING = 2'b10  // Stop seen, rider still standing on the deck
    } auth_state_t;

endpackage

// ==== hw/auth_top.sv ====
`timescale 1ns/100ps

module auth_top #(
    parameter int                BAUD_DIV     = 434,
    parameter auth_pkg::weight_t MIN_RIDER_WT = 13'h0200,
    parameter auth_pkg::weight_t WT_HYST      = 13'h0040
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx,         // BLE serial line
    input  auth_pkg::ld_cell_t ld,
    output logic               pwr_up,
    output logic               rider_off   // Also read by the balance controller
);

    import auth_pkg::*;

    logic  rx_rdy;
    byte_t rx_data;
    logic  clr_rdy;

    uart_rx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .clr_rdy (clr_rdy),
        .rdy     (rx_rdy),
        .rx_data (rx_data)
    );

    rider_detect #(
        .MIN_RIDER_WT (MIN_RIDER_WT),
        .WT_HYST      (WT_HYST)
    ) u_rider (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld        (ld),
        .rider_off (rider_off)
    );

    auth_blk u_auth (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_rdy    (rx_rdy),
        .rx_data   (rx_data),
        .rider_off (rider_off),
        .clr_rdy   (clr_rdy),
        .pwr_up    (pwr_up)
    );

endmodule

// ==== hw/rider_detect.sv ====
`timescale 1ns/100ps

module rider_detect #(
    parameter auth_pkg::weight_t MIN_RIDER_WT = 13'h0200,
    parameter auth_pkg::weight_t WT_HYST      = 13'h0040
) (
    input  logic               clk,
    input  logic               rst_n,
    input  auth_pkg::ld_cell_t ld,         // Left and right load cells
    output logic               rider_off
);

    import auth_pkg::*;

    // Switching points on either side of the nominal rider weight
    localparam weight_t LO_LIM = MIN_RIDER_WT - WT_HYST;
    localparam weight_t HI_LIM = MIN_RIDER_WT + WT_HYST;

    weight_t wt_sum;
    logic    below_lo;
    logic    above_hi;

    // Zero extend both cells before adding
    assign wt_sum = weight_t'(ld.lft) + weight_t'(ld.rght);

    assign below_lo = (wt_sum < LO_LIM);  // Clearly stepped off
    assign above_hi = (wt_sum > HI_LIM);  // Clearly standing on

    // Inside the band the old value is kept, so weight shifts
    // near the threshold do not make rider_off chatter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rider_off <= 1'b1;            // No rider until the cells say so
        end else if (below_lo) begin
            rider_off <= 1'b1;
        end else if (above_hi) begin
            rider_off <= 1'b0;
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx #(
    parameter int BAUD_DIV = 434
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx,       // Serial line from the BLE module, idles high
    input  logic            clr_rdy,
    output logic            rdy,
    output auth_pkg::byte_t rx_data
);

    import auth_pkg::*;

    localparam int FRAME_BITS = BYTE_W + 2;            // Start, data, stop
    localparam int CNT_W      = $clog2(BAUD_DIV);
    localparam int BIT_W      = $clog2(FRAME_BITS + 1);

    typedef enum logic {
        IDLE,
        RECEIVE
    } rx_state_t;

    rx_state_t             state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic [CNT_W-1:0]      baud_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shift_reg;
    logic                  start_det;
    logic                  sample;
    logic                  frame_done;

    // Two flops against metastability on the asynchronous line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Line low while idle means a start bit has begun
    assign start_det  = (state == IDLE) && !rx_sync;
    assign sample     = (state == RECEIVE) && (baud_cnt == '0);      // Mid-bit point
    assign frame_done = (state == RECEIVE) && (bit_cnt == BIT_W'(FRAME_BITS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (start_det) begin
            state <= RECEIVE;
        end else if (frame_done) begin
            state <= IDLE;
        end
    end

    // First wait is half a bit so every sample lands in the middle of its bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (start_det) begin
            baud_cnt <= CNT_W'(BAUD_DIV / 2 - 1);
            bit_cnt  <= '0;
        end else if (sample) begin
            baud_cnt <= CNT_W'(BAUD_DIV - 1);
            bit_cnt  <= bit_cnt + 1'b1;
        end else if (state == RECEIVE) begin
            baud_cnt <= baud_cnt - 1'b1;
        end
    end

    // Shift right so the start bit ends in bit 0 and data sits LSB first above it
    always_ff @(posedge clk) begin
        if (sample) begin
            shift_reg <= {rx_sync, shift_reg[FRAME_BITS-1:1]};
        end
    end

    assign rx_data = shift_reg[BYTE_W:1];

    // Ready is held until the consumer clears it or another frame starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy <= 1'b0;
        end else if (frame_done) begin
            rdy <= 1'b1;
        end else if (clr_rdy || start_det) begin
            rdy <= 1'b0;
        end
    end

endmodule

// ==== tb.f ====
hw/auth_pkg.sv
hw/uart_rx.sv
hw/rider_detect.sv
hw/auth_blk.sv
hw/auth_top.sv
test/clk_gen.sv
test/auth_sva.sv
test/tb_auth.sv

// ==== test/auth_sva.sv ====
`timescale 1ns/100ps

module auth_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  rx_rdy,
    input logic                  clr_rdy,
    input logic                  pwr_up,
    input auth_pkg::auth_state_t state
);

    import auth_pkg::*;

    int fail_cnt = 0;  // Read by the testbench for the final verdict

    // Clear is a single pulse on the first cycle of ready
    a_clr_needs_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        clr_rdy |-> $rose(rx_rdy))
        else begin
            $error("clr_rdy high outside the first cycle of rx_rdy");
            fail_cnt++;
        end

    // Ready must be gone the cycle after the clear
    a_rdy_drops: assert property (@(posedge clk) disable iff (!rst_n)
        clr_rdy |=> !rx_rdy)
        else begin
            $error("rx_rdy still high one cycle after clr_rdy");
            fail_cnt++;
        end

    a_pwr_decode: assert property (@(posedge clk) disable iff (!rst_n)
        pwr_up == (state != POWERED_DOWN))
        else begin
            $error("pwr_up does not match the FSM state");
            fail_cnt++;
        end

    // A stop can only be pending if power was on
    a_no_down_to_pending: assert property (@(posedge clk) disable iff (!rst_n)
        (state == POWERED_DOWN && rx_rdy) |=> (state != STOP_PENDING))
        else begin
            $error("FSM went from POWERED_DOWN straight to STOP_PENDING");
            fail_cnt++;
        end

endmodule

bind auth_blk auth_sva u_auth_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx_rdy  (rx_rdy),
    .clr_rdy (clr_rdy),
    .pwr_up  (pwr_up),
    .state   (state)
);

// ==== test/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_NS = 2  // 4 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_NS) clk = ~clk;
    end

endmodule

// ==== test/tb_auth.sv ====
`timescale 1ns/100ps

module tb_auth;

    import auth_pkg::*;

    localparam int      BAUD_DIV     = 16;
    localparam weight_t MIN_RIDER_WT = 13'h0200;
    localparam weight_t WT_HYST      = 13'h0040;
    localparam int      CLK_NS       = 4;
    localparam int      N_RAND       = 40;
    localparam int      TOTAL_FRAMES = 9 + N_RAND;  // Directed frames plus random ones
    localparam int      WATCHDOG_NS  = (TOTAL_FRAMES * 12 + 64) * BAUD_DIV * CLK_NS;

    logic     clk;
    logic     rst_n;
    logic     rx;
    ld_cell_t ld;
    logic     pwr_up;
    logic     rider_off;

    auth_state_t model_state;
    logic        model_ro;
    logic        check_req = 1'b0;
    int          rx_count  = 0;
    int          err_count = 0;
    int          chk_count = 0;
    int          test_base;
    integer      seed;

    clk_gen u_clk (
        .clk (clk)
    );

    auth_top #(
        .BAUD_DIV     (BAUD_DIV),
        .MIN_RIDER_WT (MIN_RIDER_WT),
        .WT_HYST      (WT_HYST)
    ) auth_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .ld        (ld),
        .pwr_up    (pwr_up),
        .rider_off (rider_off)
    );

    // Counts bytes taken by the FSM
    always @(posedge clk) begin
        if (auth_top_inst.u_auth.clr_rdy) begin
            rx_count <= rx_count + 1;
        end
    end

    function automatic auth_state_t next_auth(auth_state_t cur, logic has_byte, byte_t b,
                                              logic ro);
        logic        go;
        logic        stop;
        auth_state_t nxt;
        go   = has_byte && (b == AUTH_GO);
        stop = has_byte && (b == AUTH_STOP);
        nxt  = cur;
        if (cur == POWERED_DOWN && go) begin
            nxt = POWERED_UP;
        end else if (cur == POWERED_UP && stop) begin
            nxt = ro ? POWERED_DOWN : STOP_PENDING;
        end else if (cur == STOP_PENDING) begin
            if (go) begin
                nxt = POWERED_UP;
            end else if (ro) begin
                nxt = POWERED_DOWN;
            end
        end
        return nxt;
    endfunction

    function automatic logic next_rider(logic ro, ld_cell_t c);
        int sum;
        sum = int'(c.lft) + int'(c.rght);
        if (sum < int'(MIN_RIDER_WT) - int'(WT_HYST)) begin
            return 1'b1;
        end else if (sum > int'(MIN_RIDER_WT) + int'(WT_HYST)) begin
            return 1'b0;
        end
        return ro;  // Inside the band
    endfunction

    // Compare process, sampled mid-cycle
    always @(negedge clk) begin
        if (check_req) begin
            chk_count++;
            assert (pwr_up === (model_state != POWERED_DOWN)) else begin
                $display("mismatch pwr_up expected %h actual %h",
                         model_state != POWERED_DOWN, pwr_up);
                err_count++;
            end
            assert (rider_off === model_ro) else begin
                $display("mismatch rider_off expected %h actual %h", model_ro, rider_off);
                err_count++;
            end
            check_req = 1'b0;
        end
    end

    task automatic check_outputs();
        @(posedge clk);
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (BAUD_DIV - 1) @(posedge clk);
        end
    endtask

    task automatic await_receive(input int prev, input byte_t b, output logic got);
        int n;
        n = 0;
        while (rx_count == prev && n < 2 * BAUD_DIV) begin
            @(posedge clk);
            n++;
        end
        got = (rx_count != prev);
        assert (got) else begin
            $display("byte %h was never taken by the FSM", b);
            err_count++;
        end
    endtask

    task automatic deliver_byte(input byte_t b);
        int   prev;
        logic got;
        prev = rx_count;
        send_byte(b);
        await_receive(prev, b, got);
        if (got) begin
            model_state = next_auth(model_state, 1'b1, b, model_ro);
        end
        check_outputs();
    endtask

    // First check lands after rider_off moves, the second after the state follows
    task automatic apply_load(input ld_val_t l, input ld_val_t r);
        ld_cell_t c;
        c.lft  = l;
        c.rght = r;
        @(posedge clk);
        ld <= c;
        model_ro = next_rider(model_ro, c);
        check_outputs();
        model_state = next_auth(model_state, 1'b0, '0, model_ro);
        check_outputs();
    endtask

    task automatic start_test();
        test_base = err_count;
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, err_count - test_base);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] r;
        byte_t       b;
        int          total;

        seed        = 32'h1fd29e6d;
        rx          = 1'b1;
        ld          = '0;
        rst_n       = 1'b0;
        model_state = POWERED_DOWN;
        model_ro    = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        check_outputs();
        apply_load(12'h180, 12'h180);  // Heavy rider
        deliver_byte(AUTH_GO);
        deliver_byte(AUTH_GO);
        finish_test(1, "reset and power up");

        start_test();
        deliver_byte(AUTH_STOP);       // Rider still on
        apply_load(12'h040, 12'h040);
        finish_test(2, "stop pending until rider off");

        start_test();
        deliver_byte(AUTH_GO);
        deliver_byte(AUTH_STOP);
        finish_test(3, "stop with rider already off");

        start_test();
        apply_load(12'h180, 12'h180);
        deliver_byte(AUTH_GO);
        deliver_byte(AUTH_STOP);
        deliver_byte(AUTH_GO);         // Cancels the pending stop
        apply_load(12'h000, 12'h010);
        deliver_byte(AUTH_STOP);
        finish_test(4, "go withdraws pending stop");

        start_test();
        apply_load(12'h0e0, 12'h0e0);  // Exactly the lower limit
        apply_load(12'h100, 12'h140);  // Exactly the upper limit
        apply_load(12'h120, 12'h100);
        apply_load(12'h121, 12'h120);  // Just above upper
        apply_load(12'h0e0, 12'h0e1);
        apply_load(12'h0e0, 12'h0e0);
        apply_load(12'h0df, 12'h0e0);  // Just below lower
        apply_load(12'hf00, 12'h180);  // Sum needs the 13th bit
        apply_load(12'hfff, 12'h000);
        apply_load(12'h000, 12'h001);
        apply_load(12'h1bf, 12'h000);
        finish_test(5, "rider hysteresis");

        start_test();
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            if ((r & 32'h7fffffff) % 3 == 0) begin
                b = r[8] ? AUTH_GO : AUTH_STOP;
            end else begin
                b = byte_t'(r[7:0]);
            end
            deliver_byte(b);
            r = $random(seed);
            if (r[0]) begin
                apply_load(ld_val_t'(($random(seed) & 32'h7fffffff) % 384),
                           ld_val_t'(($random(seed) & 32'h7fffffff) % 384));
            end
        end
        finish_test(6, "random bytes and loads");

        total = err_count + auth_top_inst.u_auth.u_auth_sva.fail_cnt;
        $display("%0d checks, %0d errors", chk_count, total);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
